/* imemPkg.sv */
package imemPkg;

    // Memory geometry
    localparam int MEM_DEPTH = 512;     // Instruction words
    localparam int PTR_W = 10;          // Holds 0..512, one more bit than the index
    localparam int DATA_W = 32;         // Instruction and bus word
    localparam int AXI_ADDR_W = 4;      // Debug register window

    // Opcodes seen by the predecoder, bits 31:26
    localparam logic [5:0] OP_BEQ = 6'd4;
    localparam logic [5:0] OP_BNE = 6'd5;
    localparam logic [5:0] OP_J = 6'd2;
    localparam logic [5:0] OP_JAL = 6'd3;

    // Debug register byte offsets
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL = 4'h0;   // W: bit0 start, bit1 clear
    localparam logic [AXI_ADDR_W-1:0] REG_INSTR = 4'h4;  // W: append at pointer
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 4'h8; // R: flags and count
    localparam logic [AXI_ADDR_W-1:0] REG_PC = 4'hC;     // R: current PC

    // AXI response codes
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Run control states
    typedef enum logic [1:0] {
        StIdle = 2'd0,  // Loading or cleared
        StRun = 2'd1,   // Fetching
        StDone = 2'd2   // End of program reached
    } RunState;

endpackage

/* axiLiteRegs.sv */
`timescale 1ns/100ps

module axiLiteRegs (
    input  logic                              i_clock,
    input  logic                              i_rst,
    // Write address and data
    input  logic [imemPkg::AXI_ADDR_W-1:0]    i_awaddr,
    input  logic                              i_awvalid,
    output logic                              o_awready,
    input  logic [imemPkg::DATA_W-1:0]        i_wdata,
    input  logic                              i_wvalid,
    output logic                              o_wready,
    // Write response
    output logic [1:0]                        o_bresp,
    output logic                              o_bvalid,
    input  logic                              i_bready,
    // Read address and data
    input  logic [imemPkg::AXI_ADDR_W-1:0]    i_araddr,
    input  logic                              i_arvalid,
    output logic                              o_arready,
    output logic [imemPkg::DATA_W-1:0]        o_rdata,
    output logic [1:0]                        o_rresp,
    output logic                              o_rvalid,
    input  logic                              i_rready,
    // Status levels from the core
    input  logic                              i_running,
    input  logic                              i_done,
    input  logic                              i_full,
    input  logic                              i_empty,
    input  logic [imemPkg::PTR_W-1:0]         i_count,
    input  logic [imemPkg::DATA_W-1:0]        i_pc,
    // Strobes to the core
    output logic                              o_loadStrobe,
    output logic [imemPkg::DATA_W-1:0]        o_loadData,
    output logic                              o_startStrobe,
    output logic                              o_clearStrobe
);

    logic wrReady;      // Shared AW/W ready
    logic wrAccept;     // AW and W taken this cycle
    logic rdAccept;     // AR taken this cycle
    logic isCtrl;
    logic isInstr;
    logic instrErr;     // Append refused
    logic [imemPkg::DATA_W-1:0] statusWord;

    assign o_awready = wrReady;
    assign o_wready = wrReady;
    assign wrAccept = wrReady && i_awvalid && i_wvalid;
    assign rdAccept = o_arready && i_arvalid;

    assign isCtrl = (i_awaddr == imemPkg::REG_CTRL);
    assign isInstr = (i_awaddr == imemPkg::REG_INSTR);
    assign instrErr = i_running || i_full;  // No append while fetching or full

    // Strobes fire in the accept cycle
    assign o_loadStrobe = wrAccept && isInstr && !instrErr;
    assign o_loadData = i_wdata;
    assign o_clearStrobe = wrAccept && isCtrl && i_wdata[1];
    assign o_startStrobe = wrAccept && isCtrl && i_wdata[0] && !i_wdata[1]; // Clear wins

    // Count in 25:16 and flags in 3:0
    assign statusWord = {6'b0, i_count, 12'b0, i_done, i_running, i_full, i_empty};

    // Ready only when both channels present and no response pending
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            wrReady <= 1'b0;
        end else begin
            wrReady <= !wrReady && i_awvalid && i_wvalid && !o_bvalid;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_bvalid <= 1'b0;
        end else if (wrAccept) begin
            o_bvalid <= 1'b1;
        end else if (i_bready) begin
            o_bvalid <= 1'b0;   // Response taken
        end
    end

    always_ff @(posedge i_clock) begin
        if (wrAccept) begin
            if (isCtrl) o_bresp <= imemPkg::RESP_OKAY;
            else if (isInstr) o_bresp <= instrErr ? imemPkg::RESP_SLVERR : imemPkg::RESP_OKAY;
            else o_bresp <= imemPkg::RESP_SLVERR; // Read-only or unmapped
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_arready <= 1'b0;
            o_rvalid <= 1'b0;
        end else begin
            o_arready <= !o_arready && i_arvalid && !o_rvalid;
            if (rdAccept) o_rvalid <= 1'b1;
            else if (i_rready) o_rvalid <= 1'b0;
        end
    end

    // Read data captured at accept
    always_ff @(posedge i_clock) begin
        if (rdAccept) begin
            case (i_araddr)
                imemPkg::REG_STATUS: begin
                    o_rdata <= statusWord;
                    o_rresp <= imemPkg::RESP_OKAY;
                end
                imemPkg::REG_PC: begin
                    o_rdata <= i_pc;
                    o_rresp <= imemPkg::RESP_OKAY;
                end
                default: begin
                    o_rdata <= '0;
                    o_rresp <= imemPkg::RESP_SLVERR;
                end
            endcase
        end
    end

endmodule

/* runControl.sv */
`timescale 1ns/100ps

module runControl (
    input  logic i_clock,
    input  logic i_rst,
    input  logic i_startStrobe,
    input  logic i_clearStrobe,
    input  logic i_empty,
    input  logic i_endReached,   // PC word index at or past the pointer
    input  logic i_advance,      // A fetch is taken this cycle
    output logic o_fetchEnable,
    output logic o_restart,      // PC back to 0
    output logic o_running,
    output logic o_done
);

    imemPkg::RunState state;
    imemPkg::RunState nextState;
    logic startOk;

    // Start only from idle or done with something loaded
    assign startOk = i_startStrobe && !i_empty && (state != imemPkg::StRun);
    assign o_restart = startOk && !i_clearStrobe;

    always_comb begin
        nextState = state;
        if (i_clearStrobe) begin
            nextState = imemPkg::StIdle; // Clear from anywhere
        end else begin
            case (state)
                imemPkg::StIdle,
                imemPkg::StDone: begin
                    if (startOk) nextState = imemPkg::StRun;
                end
                imemPkg::StRun: begin
                    if (i_endReached) nextState = imemPkg::StDone;
                end
                default: nextState = imemPkg::StIdle;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state <= imemPkg::StIdle;
        end else begin
            state <= nextState;
        end
    end

    assign o_running = (state == imemPkg::StRun);
    assign o_done = (state == imemPkg::StDone);
    assign o_fetchEnable = o_running && !i_endReached; // No fetch past the end

    // Top-level advance must follow the enable given here
    aAdvanceRun: assert property (@(posedge i_clock) disable iff (i_rst)
        i_advance |-> (state == imemPkg::StRun) && !i_endReached)
        else $error("Fetch advanced outside run");

endmodule

/* fetchCounter.sv */
`timescale 1ns/100ps

module fetchCounter (
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  logic                         i_restart,
    input  logic                         i_advance,
    input  logic                         i_isJump,
    input  logic [imemPkg::DATA_W-1:0]   i_jumpTarget,
    output logic [imemPkg::DATA_W-1:0]   o_pc,
    output logic [imemPkg::DATA_W-3:0]   o_pcWordIndex
);

    logic [imemPkg::DATA_W-1:0] pcPlus4;

    assign pcPlus4 = o_pc + 32'd4;

    // Restart beats advance, otherwise hold
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_pc <= '0;
        end else if (i_restart) begin
            o_pc <= '0;
        end else if (i_advance) begin
            o_pc <= i_isJump ? i_jumpTarget : pcPlus4; // No delay slot
        end
    end

    assign o_pcWordIndex = o_pc[imemPkg::DATA_W-1:2]; // Drop byte offset

    aPcAligned: assert property (@(posedge i_clock) disable iff (i_rst)
        o_pc[1:0] == 2'b00)
        else $error("PC not word aligned");

endmodule

/* instructionMemory.sv */
`timescale 1ns/100ps

module instructionMemory (
    input  logic                         i_clock,
    input  logic                         i_rst,
    input  logic                         i_clear,
    input  logic                         i_instWrite,
    input  logic [imemPkg::DATA_W-1:0]   i_instruction,
    input  logic [imemPkg::DATA_W-3:0]   i_readIndex,
    output logic [imemPkg::DATA_W-1:0]   o_readData,
    output logic                         o_full,
    output logic                         o_empty,
    output logic [imemPkg::PTR_W-1:0]    o_count
);

    logic [imemPkg::DATA_W-1:0] memory [imemPkg::MEM_DEPTH];
    logic [imemPkg::PTR_W-1:0] pointer;   // Next free slot, saturates at 512
    logic inRange;

    // Pointer only; stale words past it are never fetched
    always_ff @(posedge i_clock) begin
        if (i_rst || i_clear) begin
            pointer <= '0;
        end else if (i_instWrite) begin
            pointer <= pointer + 1'b1;
        end
    end

    // Store, low index bits of the pointer
    always_ff @(posedge i_clock) begin
        if (i_instWrite) begin
            memory[pointer[imemPkg::PTR_W-2:0]] <= i_instruction;
        end
    end

    assign inRange = (i_readIndex < imemPkg::MEM_DEPTH);

    // Async read like a ROM
    always_comb begin
        if (inRange) begin
            o_readData = memory[i_readIndex[imemPkg::PTR_W-2:0]];
        end else begin
            o_readData = '0;    // Outside the array
        end
    end

    assign o_full = (pointer == imemPkg::PTR_W'(imemPkg::MEM_DEPTH));
    assign o_empty = (pointer == '0);
    assign o_count = pointer;

    aNoWriteFull: assert property (@(posedge i_clock) disable iff (i_rst)
        i_instWrite |-> !o_full)
        else $error("Write into full instruction memory");

endmodule

/* instPredecode.sv */
`timescale 1ns/100ps

module instPredecode (
    input  logic [imemPkg::DATA_W-1:0] i_instruction,
    input  logic [imemPkg::DATA_W-1:0] i_pc,
    output logic                       o_isBranch,
    output logic                       o_isJump,
    output logic [imemPkg::DATA_W-1:0] o_jumpTarget
);

    logic [5:0] opcode;
    logic [imemPkg::DATA_W-1:0] pcPlus4;

    assign opcode = i_instruction[31:26];
    assign pcPlus4 = i_pc + 32'd4;

    // Both flags driven on every path
    always_comb begin
        o_isBranch = 1'b0;
        o_isJump = 1'b0;
        case (opcode)
            imemPkg::OP_BEQ,
            imemPkg::OP_BNE: o_isBranch = 1'b1;  // Condition resolved later
            imemPkg::OP_J,
            imemPkg::OP_JAL: o_isJump = 1'b1;
            default: ;
        endcase
    end

    // J-type: region of PC+4, index field times 4
    assign o_jumpTarget = {pcPlus4[31:28], i_instruction[25:0], 2'b00};

endmodule

/* fetchTop.sv */
`timescale 1ns/100ps

module fetchTop (
    input  logic                              i_clock,
    input  logic                              i_rst,
    // AXI4-Lite debug port
    input  logic [imemPkg::AXI_ADDR_W-1:0]    i_awaddr,
    input  logic                              i_awvalid,
    output logic                              o_awready,
    input  logic [imemPkg::DATA_W-1:0]        i_wdata,
    input  logic                              i_wvalid,
    output logic                              o_wready,
    output logic [1:0]                        o_bresp,
    output logic                              o_bvalid,
    input  logic                              i_bready,
    input  logic [imemPkg::AXI_ADDR_W-1:0]    i_araddr,
    input  logic                              i_arvalid,
    output logic                              o_arready,
    output logic [imemPkg::DATA_W-1:0]        o_rdata,
    output logic [1:0]                        o_rresp,
    output logic                              o_rvalid,
    input  logic                              i_rready,
    // Fetch stream
    input  logic                              i_fetchReady,
    output logic                              o_fetchValid,
    output logic [imemPkg::DATA_W-1:0]        o_instruction,
    output logic [imemPkg::DATA_W-1:0]        o_fetchPc,
    output logic                              o_isBranch,
    output logic                              o_isJump
);

    logic loadStrobe;
    logic [imemPkg::DATA_W-1:0] loadData;
    logic startStrobe;
    logic clearStrobe;
    logic running;
    logic done;
    logic full;
    logic empty;
    logic [imemPkg::PTR_W-1:0] count;
    logic [imemPkg::DATA_W-1:0] pc;
    logic [imemPkg::DATA_W-3:0] pcWordIndex;
    logic [imemPkg::DATA_W-3:0] countWide;
    logic [imemPkg::DATA_W-1:0] readData;
    logic isBranch;
    logic isJump;
    logic [imemPkg::DATA_W-1:0] jumpTarget;
    logic fetchEnable;
    logic restart;
    logic endReached;
    logic advance;

    assign countWide = {{(imemPkg::DATA_W - 2 - imemPkg::PTR_W){1'b0}}, count};
    assign endReached = (pcWordIndex >= countWide);  // Past last loaded word
    assign advance = fetchEnable && (!o_fetchValid || i_fetchReady); // Slot free or draining

    axiLiteRegs u_regs (
        .i_clock(i_clock), .i_rst(i_rst),
        .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
        .i_wdata(i_wdata), .i_wvalid(i_wvalid), .o_wready(o_wready),
        .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
        .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
        .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
        .i_running(running), .i_done(done), .i_full(full), .i_empty(empty),
        .i_count(count), .i_pc(pc),
        .o_loadStrobe(loadStrobe), .o_loadData(loadData),
        .o_startStrobe(startStrobe), .o_clearStrobe(clearStrobe)
    );

    runControl u_ctrl (
        .i_clock(i_clock), .i_rst(i_rst),
        .i_startStrobe(startStrobe), .i_clearStrobe(clearStrobe), .i_empty(empty),
        .i_endReached(endReached), .i_advance(advance),
        .o_fetchEnable(fetchEnable), .o_restart(restart),
        .o_running(running), .o_done(done)
    );

    fetchCounter u_pc (
        .i_clock(i_clock), .i_rst(i_rst),
        .i_restart(restart), .i_advance(advance),
        .i_isJump(isJump), .i_jumpTarget(jumpTarget),
        .o_pc(pc), .o_pcWordIndex(pcWordIndex)
    );

    instructionMemory u_imem (
        .i_clock(i_clock), .i_rst(i_rst),
        .i_clear(clearStrobe), .i_instWrite(loadStrobe), .i_instruction(loadData),
        .i_readIndex(pcWordIndex), .o_readData(readData),
        .o_full(full), .o_empty(empty), .o_count(count)
    );

    instPredecode u_predec (
        .i_instruction(readData), .i_pc(pc),
        .o_isBranch(isBranch), .o_isJump(isJump), .o_jumpTarget(jumpTarget)
    );

    // Output stage valid
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            o_fetchValid <= 1'b0;
        end else if (advance) begin
            o_fetchValid <= 1'b1;
        end else if (i_fetchReady) begin
            o_fetchValid <= 1'b0;   // Beat taken, nothing new
        end
    end

    // Payload held while stalled
    always_ff @(posedge i_clock) begin
        if (advance) begin
            o_instruction <= readData;
            o_fetchPc <= pc;
            o_isBranch <= isBranch;
            o_isJump <= isJump;
        end
    end

endmodule

/* tbFetchTop.sv */
`timescale 1ns/100ps

module tbFetchTop;

    localparam int WAIT_LIMIT = 1000;   // Cycles or polls per wait loop
    localparam int PROG_LEN = 20;

    // One expected stream beat
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] word;
        logic        isBranch;
        logic        isJump;
    } Beat;
    typedef Beat BeatQueue[$];

    logic        i_clock;
    logic        i_rst;
    logic [3:0]  i_awaddr;
    logic        i_awvalid;
    logic        o_awready;
    logic [31:0] i_wdata;
    logic        i_wvalid;
    logic        o_wready;
    logic [1:0]  o_bresp;
    logic        o_bvalid;
    logic        i_bready;
    logic [3:0]  i_araddr;
    logic        i_arvalid;
    logic        o_arready;
    logic [31:0] o_rdata;
    logic [1:0]  o_rresp;
    logic        o_rvalid;
    logic        i_rready;
    logic        i_fetchReady;
    logic        o_fetchValid;
    logic [31:0] o_instruction;
    logic [31:0] o_fetchPc;
    logic        o_isBranch;
    logic        o_isJump;

    int seed;
    int rnd;
    int checkErrs;      // Wrong values
    int otherErrs;      // Unexpected beats and timeouts
    string testName;
    logic timedOut;     // A wait loop gave up
    logic readyRandom;  // Back-pressure on
    logic stalled;
    Beat held;          // Stream values seen while stalled
    Beat expBeat;
    BeatQueue expQ;
    logic [31:0] prog[$];

    fetchTop i_fetchTop (.*);

    always #2 i_clock = ~i_clock;   // 4 ns period

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (expected === actual) else begin
            checkErrs++;
            $display("CHECK FAILED %s/%s: expected %h, actual %h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic reportTimeout(input string what);
        otherErrs++;
        $display("Timeout in %s: %s", testName, what);
        timedOut = 1'b1;
    endtask

    task automatic writeReg(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        n = 0;
        i_awaddr <= addr;
        i_awvalid <= 1'b1;
        i_wdata <= data;
        i_wvalid <= 1'b1;
        @(posedge i_clock);
        while (!o_awready) begin   // AW and W taken together
            n++;
            if (n > WAIT_LIMIT) reportTimeout("write address and data never accepted");
            @(posedge i_clock);
        end
        i_awvalid <= 1'b0;
        i_wvalid <= 1'b0;
        i_bready <= 1'b1;
        n = 0;
        @(posedge i_clock);
        while (!o_bvalid) begin
            n++;
            if (n > WAIT_LIMIT) reportTimeout("write response never arrived");
            @(posedge i_clock);
        end
        resp = o_bresp;
        i_bready <= 1'b0;
    endtask

    task automatic readReg(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        int n;
        n = 0;
        i_araddr <= addr;
        i_arvalid <= 1'b1;
        @(posedge i_clock);
        while (!o_arready) begin
            n++;
            if (n > WAIT_LIMIT) reportTimeout("read address never accepted");
            @(posedge i_clock);
        end
        i_arvalid <= 1'b0;
        i_rready <= 1'b1;
        n = 0;
        @(posedge i_clock);
        while (!o_rvalid) begin
            n++;
            if (n > WAIT_LIMIT) reportTimeout("read data never arrived");
            @(posedge i_clock);
        end
        data = o_rdata;
        resp = o_rresp;
        i_rready <= 1'b0;
    endtask

    // Expected fetch order from the PC rules without a delay slot
    function automatic BeatQueue refRun(input logic [31:0] words[$],
                                        input logic [31:0] startPc,
                                        output logic [31:0] endPc);
        BeatQueue beats;
        Beat b;
        logic [31:0] pc;
        logic [31:0] pcPlus4;
        logic [5:0] op;
        int steps;
        pc = startPc;
        steps = 0;
        while ((pc >> 2) < words.size() && steps < 2048) begin  // Ends at write pointer
            b.pc = pc;
            b.word = words[pc >> 2];
            op = b.word[31:26];
            b.isBranch = (op == 6'd4) || (op == 6'd5);  // BEQ, BNE
            b.isJump = (op == 6'd2) || (op == 6'd3);    // J, JAL
            beats.push_back(b);
            pcPlus4 = pc + 32'd4;
            pc = b.isJump ? {pcPlus4[31:28], b.word[25:0], 2'b00} : pcPlus4;
            steps++;
        end
        endPc = pc;
        return beats;
    endfunction

    // Random mix of branches, jumps and other ops
    task automatic buildProgram(input int len);
        int kind;
        int target;
        logic [5:0] op;
        logic [25:0] field;
        prog.delete();
        for (int i = 0; i < len; i++) begin
            kind = {$random(seed)} % 5;
            field = 26'($random(seed));
            case (kind)
                0: op = 6'd4;
                1: op = 6'd5;
                2: op = 6'd2;
                3: op = 6'd3;
                default: op = 6'd8 + 6'({$random(seed)} % 24);  // Never 2..5
            endcase
            // Forward jumps inside the program so every run ends
            if (op == 6'd2 || op == 6'd3) begin
                if (i < len - 1) begin
                    target = i + 1 + {$random(seed)} % (len - 1 - i);
                    field = 26'(target);
                end else begin
                    op = 6'd0;  // Last word falls through
                end
            end
            prog.push_back({op, field});
        end
    endtask

    task automatic loadProgram();
        logic [1:0] resp;
        foreach (prog[i]) begin
            writeReg(imemPkg::REG_INSTR, prog[i], resp);
            checkValue("load resp", imemPkg::RESP_OKAY, resp);
        end
    endtask

    task automatic waitDrain();
        int n;
        n = 0;
        while (expQ.size() != 0) begin
            n++;
            if (n > WAIT_LIMIT) reportTimeout("expected beats never arrived");
            @(posedge i_clock);
        end
    endtask

    task automatic waitDone();
        logic [31:0] status;
        logic [1:0] resp;
        int n;
        n = 0;
        readReg(imemPkg::REG_STATUS, status, resp);
        while (!status[3]) begin   // Done flag
            n++;
            if (n > WAIT_LIMIT) reportTimeout("done never set");
            readReg(imemPkg::REG_STATUS, status, resp);
        end
    endtask

    // Stream monitor sampling on the same edge as the DUT
    always @(posedge i_clock) begin
        if (readyRandom) begin
            rnd = $random(seed);
            i_fetchReady <= rnd[0];
        end
        if (i_rst || !o_fetchValid) begin
            stalled = 1'b0;
        end else begin
            if (stalled) begin  // Must not move while held
                checkValue("stall pc", held.pc, o_fetchPc);
                checkValue("stall word", held.word, o_instruction);
                checkValue("stall flags", {held.isBranch, held.isJump}, {o_isBranch, o_isJump});
            end
            if (i_fetchReady) begin
                assert (expQ.size() != 0) else begin
                    otherErrs++;
                    $display("Unexpected fetch beat at PC %h in %s", o_fetchPc, testName);
                end
                if (expQ.size() != 0) begin
                    expBeat = expQ.pop_front();
                    checkValue("beat pc", expBeat.pc, o_fetchPc);
                    checkValue("beat word", expBeat.word, o_instruction);
                    checkValue("beat branch", expBeat.isBranch, o_isBranch);
                    checkValue("beat jump", expBeat.isJump, o_isJump);
                end
                stalled = 1'b0;
            end else begin
                stalled = 1'b1;
                held = {o_fetchPc, o_instruction, o_isBranch, o_isJump};
            end
        end
    end

    // Ends the run as soon as a wait loop gives up
    initial begin
        wait (timedOut === 1'b1);
        $display("Errors: %0d value mismatches, %0d other failures", checkErrs, otherErrs);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [31:0] data;
        logic [1:0] resp;
        logic [31:0] endPc;
        seed = 9654;
        checkErrs = 0;
        otherErrs = 0;
        timedOut = 1'b0;
        readyRandom = 1'b0;
        stalled = 1'b0;
        held = '0;
        testName = "reset";
        i_clock = 1'b0;
        i_rst = 1'b1;
        i_awaddr = '0;
        i_awvalid = 1'b0;
        i_wdata = '0;
        i_wvalid = 1'b0;
        i_bready = 1'b0;
        i_araddr = '0;
        i_arvalid = 1'b0;
        i_rready = 1'b0;
        i_fetchReady = 1'b1;
        repeat (8) @(posedge i_clock);
        i_rst <= 1'b0;
        @(posedge i_clock);
        checkValue("fetch valid", 1'b0, o_fetchValid);

        testName = "load";
        readReg(imemPkg::REG_STATUS, data, resp);
        checkValue("status after reset", 32'h1, data);  // Empty, count 0
        buildProgram(PROG_LEN);
        loadProgram();
        readReg(imemPkg::REG_STATUS, data, resp);
        checkValue("status resp", imemPkg::RESP_OKAY, resp);
        checkValue("status loaded", 32'(PROG_LEN) << 16, data);

        testName = "run";
        expQ = refRun(prog, 32'd0, endPc);
        writeReg(imemPkg::REG_CTRL, 32'h1, resp);
        checkValue("start resp", imemPkg::RESP_OKAY, resp);
        waitDrain();
        waitDone();
        readReg(imemPkg::REG_PC, data, resp);
        checkValue("end pc", endPc, data);
        readReg(imemPkg::REG_STATUS, data, resp);
        checkValue("status done", (32'(PROG_LEN) << 16) | 32'h8, data);

        testName = "backpressure";
        expQ = refRun(prog, 32'd0, endPc);
        readyRandom <= 1'b1;
        writeReg(imemPkg::REG_CTRL, 32'h1, resp);
        waitDrain();
        waitDone();
        readyRandom <= 1'b0;
        @(posedge i_clock);

        testName = "errors";
        i_fetchReady <= 1'b0;   // First beat stalls and the run stays active
        expQ = refRun(prog, 32'd0, endPc);
        writeReg(imemPkg::REG_CTRL, 32'h1, resp);
        writeReg(imemPkg::REG_INSTR, 32'h1234_5678, resp);
        checkValue("instr while running", imemPkg::RESP_SLVERR, resp);
        readReg(imemPkg::REG_STATUS, data, resp);
        checkValue("status running", (32'(PROG_LEN) << 16) | 32'h4, data);
        readReg(4'h2, data, resp);
        checkValue("unmapped read", imemPkg::RESP_SLVERR, resp);
        i_fetchReady <= 1'b1;
        waitDrain();
        waitDone();

        testName = "full";
        writeReg(imemPkg::REG_CTRL, 32'h2, resp);
        checkValue("clear resp", imemPkg::RESP_OKAY, resp);
        for (int i = 0; i < 512; i++) begin
            data = $random(seed);
            writeReg(imemPkg::REG_INSTR, data, resp);
            checkValue("fill resp", imemPkg::RESP_OKAY, resp);
        end
        readReg(imemPkg::REG_STATUS, data, resp);
        checkValue("status full", (32'd512 << 16) | 32'h2, data);
        writeReg(imemPkg::REG_INSTR, 32'hCAFE_0001, resp);
        checkValue("write when full", imemPkg::RESP_SLVERR, resp);
        readReg(imemPkg::REG_STATUS, data, resp);
        checkValue("count after overflow", (32'd512 << 16) | 32'h2, data);

        testName = "clear";
        writeReg(imemPkg::REG_CTRL, 32'h2, resp);
        readReg(imemPkg::REG_STATUS, data, resp);
        checkValue("status cleared", 32'h1, data);     // Empty, idle, count 0
        writeReg(imemPkg::REG_CTRL, 32'h1, resp);      // Start on empty memory
        checkValue("start resp", imemPkg::RESP_OKAY, resp);
        readReg(imemPkg::REG_STATUS, data, resp);
        checkValue("status no run", 32'h1, data);
        @(posedge i_clock);

        $display("Errors: %0d value mismatches, %0d other failures", checkErrs, otherErrs);
        if (checkErrs == 0 && otherErrs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
imemPkg.sv
axiLiteRegs.sv
runControl.sv
fetchCounter.sv
instructionMemory.sv
instPredecode.sv
fetchTop.sv
tbFetchTop.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build and run the fetch front-end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbFetchTop -f flist.f -o simv

output="$(./obj_dir/simv)"
echo "$output"

if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
